// File: hdl/ingress_pkg.sv
//////////////////////////////
// Byte 0 of every data field is the first byte on the wire
//////////////////////////////

`default_nettype none

`include "ingress_macros.svh"

package ingress_pkg;

    //////////////////////////////
    // Receive port beats
    //////////////////////////////

    // One byte per beat with the end-of-packet marker
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } beat8_t;

    // Two bytes per beat, data[7:0] is the earlier byte
    // The upper byte may only be empty on the last beat of a packet
    typedef struct packed {
        logic        last;
        logic        upper_valid;
        logic [15:0] data;
    } beat16_t;

    //////////////////////////////
    // Packed words and output bus
    //////////////////////////////

    // Keep is contiguous from bit 0 and marks the bytes that carry data
    typedef struct packed {
        logic                         last;
        logic [`ING_WORD_BYTES-1:0]   keep;
        logic [8*`ING_WORD_BYTES-1:0] data;
    } word_t;

    // Output bus word tagged with the receive port it came from
    typedef struct packed {
        word_t                      word;
        logic [`ING_PORT_IDX_W-1:0] port;
    } ing_bus_t;

endpackage

`default_nettype wire

// File: hdl/ingress_port_buffer.sv
//////////////////////////////
// Never stalls the writer. A packet that hits a full buffer is dropped whole
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ingress_macros.svh"

module ingress_port_buffer (
    input  var logic               ing_clk,
    input  var logic               reset,
    input  var ingress_pkg::word_t word,
    input  var logic               word_valid,
    input  var logic               pop,
    input  var logic               ovf_clear,
    output ingress_pkg::word_t     head,
    output logic                   pkt_ready,
    output logic                   overflow
);

    localparam int DEPTH  = `ING_BUF_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    // Word storage, read asynchronously at the read pointer
    ingress_pkg::word_t mem [DEPTH];

    // Pointers carry one extra bit so full and empty differ
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] start_ptr;
    logic [ADDR_W:0] used;
    logic [ADDR_W:0] pkt_cnt;
    logic            full;
    logic            discarding;
    logic            wr_en;
    logic            ovf_hit;
    logic            store_last;
    logic            pop_last;

    //////////////////////////////
    // Occupancy and write control
    //////////////////////////////

    assign used = wr_ptr - rd_ptr;
    assign full = (used == (ADDR_W + 1)'(DEPTH));

    // Words of a dropped packet are ignored up to and including its last word
    assign wr_en   = word_valid && !discarding && !full;
    assign ovf_hit = word_valid && !discarding && full;

    assign store_last = wr_en && word.last;
    assign pop_last   = pop && head.last;

    always_ff @(posedge ing_clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= word;
        end
    end

    //////////////////////////////
    // Pointer and packet tracking
    //////////////////////////////

    always_ff @(posedge ing_clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            start_ptr  <= '0;
            discarding <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                // The next packet begins right after a stored last word
                if (word.last) begin
                    start_ptr <= wr_ptr + 1'b1;
                end
            end else if (ovf_hit) begin
                // Roll back over the partial packet already written
                wr_ptr     <= start_ptr;
                discarding <= !word.last;
            end
            if (discarding && word_valid && word.last) begin
                discarding <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Complete packets held in the buffer
    always_ff @(posedge ing_clk) begin
        if (reset) begin
            pkt_cnt <= '0;
        end else begin
            case ({store_last, pop_last})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

    assign pkt_ready = (pkt_cnt != '0);
    assign head      = mem[rd_ptr[ADDR_W-1:0]];

    //////////////////////////////
    // Overflow flag
    //////////////////////////////

    // Sticky until cleared, a new drop wins over a clear in the same cycle
    always_ff @(posedge ing_clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (ovf_hit) begin
            overflow <= 1'b1;
        end else if (ovf_clear) begin
            overflow <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ingress_scheduler.sv
//////////////////////////////
// Serves whole packets only. One idle cycle separates consecutive packets
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ingress_macros.svh"

module ingress_scheduler (
    input  var logic                      ing_clk,
    input  var logic                      reset,
    input  var logic [`ING_NUM_PORTS-1:0] pkt_ready,
    input  var ingress_pkg::word_t        heads [`ING_NUM_PORTS-1:0],
    output logic [`ING_NUM_PORTS-1:0]     pop,
    output ingress_pkg::ing_bus_t         out_bus,
    output logic                          out_valid,
    input  var logic                      out_ready,
    input  var logic                      out_cnt_clear,
    output logic [`ING_CNT_W-1:0]         out_pkt_cnt
);

    localparam int N     = `ING_NUM_PORTS;
    localparam int IDX_W = `ING_PORT_IDX_W;

    logic               busy;
    logic [IDX_W-1:0]   cur_port;
    logic [IDX_W-1:0]   next_port;
    logic               found;
    logic               load;
    ingress_pkg::word_t cur_head;

    //////////////////////////////
    // Round-robin arbiter
    //////////////////////////////

    // Search starts at the port after the one served last
    always_comb begin
        int idx;
        found     = 1'b0;
        next_port = cur_port;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(cur_port) + k) % N;
            if (!found && pkt_ready[idx]) begin
                found     = 1'b1;
                next_port = IDX_W'(idx);
            end
        end
    end

    // The grant stays locked until the last word of the packet is loaded
    // Once idle the current port is the last one served
    always_ff @(posedge ing_clk) begin
        if (reset) begin
            busy     <= 1'b0;
            cur_port <= IDX_W'(N - 1);
        end else if (!busy) begin
            if (found) begin
                busy     <= 1'b1;
                cur_port <= next_port;
            end
        end else if (load && cur_head.last) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////
    // Word transfer
    //////////////////////////////

    assign cur_head = heads[cur_port];

    // Take a word whenever the output register is empty or draining
    assign load = busy && (!out_valid || out_ready);

    always_comb begin
        pop           = '0;
        pop[cur_port] = load;
    end

    always_ff @(posedge ing_clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Output register holds its word while the sink is stalled
    always_ff @(posedge ing_clk) begin
        if (load) begin
            out_bus.word <= cur_head;
            out_bus.port <= cur_port;
        end
    end

    //////////////////////////////
    // Output packet counter
    //////////////////////////////

    // Counts packets whose last word is accepted and sticks at the maximum
    always_ff @(posedge ing_clk) begin
        if (reset || out_cnt_clear) begin
            out_pkt_cnt <= '0;
        end else if (out_valid && out_ready && out_bus.word.last && !(&out_pkt_cnt)) begin
            out_pkt_cnt <= out_pkt_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ingress_top.sv
//////////////////////////////
// Byte ports take indices 0 and 1, the halfword port takes index 2
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ingress_macros.svh"

module ingress_top (
    input  var logic                         ing_clk,
    input  var logic                         reset,
    input  var ingress_pkg::beat8_t          beats8 [`ING_NUM_8B_PORTS-1:0],
    input  var logic [`ING_NUM_8B_PORTS-1:0] beats8_valid,
    input  var ingress_pkg::beat16_t         beat16,
    input  var logic                         beat16_valid,
    input  var logic [`ING_NUM_PORTS-1:0]    port_enable,
    input  var logic [`ING_NUM_PORTS-1:0]    cnt_clear,
    input  var logic [`ING_NUM_PORTS-1:0]    ovf_clear,
    output logic [`ING_CNT_W-1:0]            pkt_cnt [`ING_NUM_PORTS-1:0],
    output logic [`ING_NUM_PORTS-1:0]        overflow,
    output ingress_pkg::ing_bus_t            out_bus,
    output logic                             out_valid,
    input  var logic                         out_ready,
    input  var logic                         out_cnt_clear,
    output logic [`ING_CNT_W-1:0]            out_pkt_cnt
);

    // Packed words from the adapters
    ingress_pkg::word_t              words [`ING_NUM_PORTS-1:0];
    logic [`ING_NUM_PORTS-1:0]       words_valid;

    // Buffer heads and handshake toward the scheduler
    ingress_pkg::word_t              heads [`ING_NUM_PORTS-1:0];
    logic [`ING_NUM_PORTS-1:0]       pkt_ready;
    logic [`ING_NUM_PORTS-1:0]       pop;

    //////////////////////////////
    // Width adapters
    //////////////////////////////

    for (genvar p = 0; p < `ING_NUM_8B_PORTS; p++) begin : gen_adapt8
        ingress_width_adapt #(
            .beat_t     ( ingress_pkg::beat8_t )
        ) adapt8_inst (
            .ing_clk    ( ing_clk         ),
            .reset      ( reset           ),
            .beat       ( beats8[p]       ),
            .beat_valid ( beats8_valid[p] ),
            .enable     ( port_enable[p]  ),
            .cnt_clear  ( cnt_clear[p]    ),
            .word       ( words[p]        ),
            .word_valid ( words_valid[p]  ),
            .pkt_cnt    ( pkt_cnt[p]      )
        );
    end

    // The halfword port sits right after the byte ports
    ingress_width_adapt #(
        .beat_t     ( ingress_pkg::beat16_t )
    ) adapt16_inst (
        .ing_clk    ( ing_clk                                ),
        .reset      ( reset                                  ),
        .beat       ( beat16                                 ),
        .beat_valid ( beat16_valid                           ),
        .enable     ( port_enable[`ING_NUM_8B_PORTS]         ),
        .cnt_clear  ( cnt_clear[`ING_NUM_8B_PORTS]           ),
        .word       ( words[`ING_NUM_8B_PORTS]               ),
        .word_valid ( words_valid[`ING_NUM_8B_PORTS]         ),
        .pkt_cnt    ( pkt_cnt[`ING_NUM_8B_PORTS]             )
    );

    //////////////////////////////
    // Packet buffers
    //////////////////////////////

    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : gen_buf
        ingress_port_buffer port_buffer_inst (
            .ing_clk    ( ing_clk        ),
            .reset      ( reset          ),
            .word       ( words[p]       ),
            .word_valid ( words_valid[p] ),
            .pop        ( pop[p]         ),
            .ovf_clear  ( ovf_clear[p]   ),
            .head       ( heads[p]       ),
            .pkt_ready  ( pkt_ready[p]   ),
            .overflow   ( overflow[p]    )
        );
    end

    //////////////////////////////
    // Output scheduler
    //////////////////////////////

    ingress_scheduler scheduler_inst (
        .ing_clk       ( ing_clk       ),
        .reset         ( reset         ),
        .pkt_ready     ( pkt_ready     ),
        .heads         ( heads         ),
        .pop           ( pop           ),
        .out_bus       ( out_bus       ),
        .out_valid     ( out_valid     ),
        .out_ready     ( out_ready     ),
        .out_cnt_clear ( out_cnt_clear ),
        .out_pkt_cnt   ( out_pkt_cnt   )
    );

endmodule

`default_nettype wire

// File: hdl/ingress_width_adapt.sv
//////////////////////////////
// Enable is sampled on the first beat of a packet and holds for the whole packet
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ingress_macros.svh"

module ingress_width_adapt #(
    parameter type beat_t = ingress_pkg::beat8_t
) (
    input  var logic                  ing_clk,
    input  var logic                  reset,
    input  var beat_t                 beat,
    input  var logic                  beat_valid,
    input  var logic                  enable,
    input  var logic                  cnt_clear,
    output ingress_pkg::word_t        word,
    output logic                      word_valid,
    output logic [`ING_CNT_W-1:0]     pkt_cnt
);

    // Beat layout is last flag on top, then an optional upper-valid flag, then data
    localparam int BEAT_BYTES = ($bits(beat_t) - 1) / 8;
    localparam int VLD_BIT    = (BEAT_BYTES > 1) ? 8 * BEAT_BYTES : 0;
    localparam int WB         = `ING_WORD_BYTES;
    localparam int FILL_W     = $clog2(WB) + 1;

    logic [$bits(beat_t)-1:0] beat_bits;
    logic [8*BEAT_BYTES-1:0]  beat_data;
    logic [FILL_W-1:0]        beat_nbytes;
    logic                     mid_pkt;
    logic                     taking;
    logic                     accept;
    logic [FILL_W-1:0]        fill;
    logic [FILL_W-1:0]        fill_next;
    logic [8*WB-1:0]          asm_data;
    logic [8*WB-1:0]          asm_next;
    logic [WB-1:0]            keep_next;
    logic                     word_done;

    //////////////////////////////
    // Beat decode
    //////////////////////////////

    assign beat_bits = beat;
    assign beat_data = beat_bits[8*BEAT_BYTES-1:0];

    // A byte-wide beat always holds one byte
    always_comb begin
        beat_nbytes = FILL_W'(1);
        if (BEAT_BYTES > 1 && beat_bits[VLD_BIT]) begin
            beat_nbytes = FILL_W'(BEAT_BYTES);
        end
    end

    // Mid-packet beats follow the decision made on the first beat
    assign accept = beat_valid && (mid_pkt ? taking : enable);

    //////////////////////////////
    // Byte packing
    //////////////////////////////

    always_comb begin
        // A fresh word starts from zero so unkept bytes read as zero
        asm_next = (fill == '0) ? '0 : asm_data;
        for (int i = 0; i < BEAT_BYTES; i++) begin
            if (i < int'(beat_nbytes) && int'(fill) + i < WB) begin
                asm_next[8*(int'(fill)+i) +: 8] = beat_data[8*i +: 8];
            end
        end
        fill_next = fill + beat_nbytes;
        for (int b = 0; b < WB; b++) begin
            keep_next[b] = (b < int'(fill_next));
        end
        // Emit on a full word or on the end of the packet
        word_done = (fill_next >= FILL_W'(WB)) || beat.last;
    end

    always_ff @(posedge ing_clk) begin
        if (reset) begin
            fill       <= '0;
            mid_pkt    <= 1'b0;
            taking     <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            // Packet boundaries are tracked on every beat, taken or not
            if (beat_valid) begin
                mid_pkt <= !beat.last;
                if (!mid_pkt) begin
                    taking <= enable;
                end
            end
            if (accept) begin
                if (word_done) begin
                    word_valid <= 1'b1;
                    fill       <= '0;
                end else begin
                    fill <= fill_next;
                end
            end
        end
    end

    // Assembly and output word registers
    always_ff @(posedge ing_clk) begin
        if (accept) begin
            asm_data <= asm_next;
            if (word_done) begin
                word.data <= asm_next;
                word.keep <= keep_next;
                word.last <= beat.last;
            end
        end
    end

    //////////////////////////////
    // Packet counter
    //////////////////////////////

    // Counts accepted packets and sticks at the maximum
    always_ff @(posedge ing_clk) begin
        if (reset || cnt_clear) begin
            pkt_cnt <= '0;
        end else if (accept && beat.last && !(&pkt_cnt)) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: include/ingress_macros.svh
//////////////////////////////
// Buffer depth must be a power of two. Port index width must cover ING_NUM_PORTS
//////////////////////////////

`ifndef INGRESS_MACROS_SVH
`define INGRESS_MACROS_SVH

// Byte-wide receive ports occupy the low port indices
`define ING_NUM_8B_PORTS 2
// Halfword ports follow the byte-wide ports in index order
`define ING_NUM_16B_PORTS 1
`define ING_NUM_PORTS (`ING_NUM_8B_PORTS + `ING_NUM_16B_PORTS)
`define ING_PORT_IDX_W 2

// Output word size in bytes
`define ING_WORD_BYTES 4
// Words held by each port buffer
`define ING_BUF_DEPTH 16
// Width of every packet counter
`define ING_CNT_W 16

`endif

// File: list.f
+incdir+include
hdl/ingress_pkg.sv
hdl/ingress_width_adapt.sv
hdl/ingress_port_buffer.sv
hdl/ingress_scheduler.sv
hdl/ingress_top.sv
tests/ingress_tb.sv

// File: tests/ingress_tb.sv
//////////////////////////////
// Each stimulus group finishes and drains before the next one starts
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ingress_macros.svh"

module ingress_tb;

    localparam int NP          = `ING_NUM_PORTS;
    localparam int P16         = `ING_NUM_8B_PORTS;
    localparam int RDY_ALWAYS  = 0;
    localparam int RDY_RANDOM  = 1;
    localparam int RDY_LOW     = 2;
    localparam int DRIVE_LIMIT = 200;
    localparam int WAIT_LIMIT  = 2000;
    localparam int QUIET       = 20;

    // One packet on one port, rows sharing a group are sent together
    typedef struct packed {
        logic [1:0] port;
        logic [7:0] len;
        logic [7:0] start;
        logic       en;
        logic [1:0] rmode;
        logic       ovf;
        logic [7:0] grp;
    } row_t;

    logic                          ing_clk;
    logic                          reset;
    ingress_pkg::beat8_t           beats8 [`ING_NUM_8B_PORTS-1:0];
    logic [`ING_NUM_8B_PORTS-1:0]  beats8_valid;
    ingress_pkg::beat16_t          beat16;
    logic                          beat16_valid;
    logic [NP-1:0]                 port_enable;
    logic [NP-1:0]                 cnt_clear;
    logic [NP-1:0]                 ovf_clear;
    logic [`ING_CNT_W-1:0]         pkt_cnt [NP-1:0];
    logic [NP-1:0]                 overflow;
    ingress_pkg::ing_bus_t         out_bus;
    logic                          out_valid;
    logic                          out_ready;
    logic                          out_cnt_clear;
    logic [`ING_CNT_W-1:0]         out_pkt_cnt;

    // Stimulus table and reference model state
    row_t                  rows [$];
    ingress_pkg::ing_bus_t exp_q [$];
    int                    grp_id;
    int                    cnt_exp [NP];
    int                    out_exp;
    logic [NP-1:0]         ovf_exp;
    int                    rdy_mode;
    logic [31:0]           lcg_state;

    // Per-port sender state
    logic [NP-1:0]         active;
    logic [7:0]            pk_len [NP];
    logic [7:0]            pk_start [NP];
    int                    pk_idx [NP];

    // Output monitor state
    logic                  stalled;
    ingress_pkg::ing_bus_t held_bus;
    logic                  in_pkt;
    logic [1:0]            pkt_port;
    int                    mon_idx;

    ingress_top ingress_top_inst (
        .ing_clk       ( ing_clk       ),
        .reset         ( reset         ),
        .beats8        ( beats8        ),
        .beats8_valid  ( beats8_valid  ),
        .beat16        ( beat16        ),
        .beat16_valid  ( beat16_valid  ),
        .port_enable   ( port_enable   ),
        .cnt_clear     ( cnt_clear     ),
        .ovf_clear     ( ovf_clear     ),
        .pkt_cnt       ( pkt_cnt       ),
        .overflow      ( overflow      ),
        .out_bus       ( out_bus       ),
        .out_valid     ( out_valid     ),
        .out_ready     ( out_ready     ),
        .out_cnt_clear ( out_cnt_clear ),
        .out_pkt_cnt   ( out_pkt_cnt   )
    );

    initial begin
        ing_clk = 1'b0;
        forever #10 ing_clk = ~ing_clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // Linear congruential generator, bit 16 has a usable period
    function automatic logic next_rand_bit();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[16];
    endfunction

    task automatic add_row(input int port, input int len, input logic [7:0] start,
                           input bit en, input int rmode, input bit ovf, input bit join_prev);
        row_t r;
        if (!join_prev) begin
            grp_id++;
        end
        r.port  = 2'(port);
        r.len   = 8'(len);
        r.start = start;
        r.en    = en;
        r.rmode = 2'(rmode);
        r.ovf   = ovf;
        r.grp   = 8'(grp_id);
        rows.push_back(r);
    endtask

    // Loads a sender and queues the words the packing rule predicts
    task automatic start_packet(input row_t r);
        ingress_pkg::ing_bus_t e;
        int n;
        port_enable[r.port] = r.en;
        pk_len[r.port]      = r.len;
        pk_start[r.port]    = r.start;
        pk_idx[r.port]      = 0;
        active[r.port]      = 1'b1;
        if (r.en) begin
            cnt_exp[r.port]++;
            if (r.ovf) begin
                ovf_exp[r.port] = 1'b1;
            end else begin
                // Four bytes per word, first byte in the low lane
                for (int k = 0; k < r.len; k += 4) begin
                    n = (r.len - k < 4) ? r.len - k : 4;
                    e = '0;
                    e.port      = r.port;
                    e.word.last = (k + 4 >= r.len);
                    for (int b = 0; b < n; b++) begin
                        e.word.data[8*b +: 8] = r.start + k + b;
                        e.word.keep[b]        = 1'b1;
                    end
                    exp_q.push_back(e);
                end
                out_exp++;
            end
        end
    endtask

    // Advances one cycle and drives every input that changes per cycle
    task automatic tick();
        @(negedge ing_clk);
        case (rdy_mode)
            RDY_ALWAYS: out_ready = 1'b1;
            RDY_RANDOM: out_ready = next_rand_bit();
            default:    out_ready = 1'b0;
        endcase
        for (int p = 0; p < P16; p++) begin
            beats8_valid[p] = active[p];
            beats8[p]       = '0;
            if (active[p]) begin
                beats8[p].data = pk_start[p] + pk_idx[p];
                beats8[p].last = (pk_idx[p] + 1 >= pk_len[p]);
                pk_idx[p]++;
                active[p] = (pk_idx[p] < pk_len[p]);
            end
        end
        // An absent upper byte carries filler that must not reach the output
        beat16_valid = active[P16];
        beat16       = '0;
        if (active[P16]) begin
            beat16.data[7:0]   = pk_start[P16] + pk_idx[P16];
            beat16.upper_valid = (pk_idx[P16] + 1 < pk_len[P16]);
            beat16.data[15:8]  = beat16.upper_valid ? pk_start[P16] + pk_idx[P16] + 1 : 8'hee;
            beat16.last        = (pk_idx[P16] + 2 >= pk_len[P16]);
            pk_idx[P16] += 2;
            active[P16] = (pk_idx[P16] < pk_len[P16]);
        end
    endtask

    task automatic drive_packets();
        int cycles;
        cycles = 0;
        while (active != '0) begin
            tick();
            cycles++;
            if (cycles > DRIVE_LIMIT) begin
                $display("Timeout while sending packets into the receive ports");
                report_failure();
            end
        end
    endtask

    // Waits until the model queue is empty, then watches a quiet period
    task automatic wait_delivery();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            tick();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout with %0d expected words still missing", exp_q.size());
                report_failure();
            end
        end
        for (int q = 0; q < QUIET; q++) begin
            tick();
        end
    endtask

    task automatic check_counters();
        for (int p = 0; p < NP; p++) begin
            check($sformatf("pkt_cnt[%0d]", p), pkt_cnt[p], cnt_exp[p]);
        end
        check("overflow", overflow, ovf_exp);
        check("out_pkt_cnt", out_pkt_cnt, out_exp);
    endtask

    //////////////////////////////
    // Output monitor
    //////////////////////////////

    // Outputs are sampled on the rising edge, inputs only move on the falling edge
    always @(posedge ing_clk) begin
        if (reset) begin
            stalled = 1'b0;
            in_pkt  = 1'b0;
        end else begin
            if (stalled) begin
                check("out_valid", out_valid, 1'b1);
                check("out_bus", out_bus, held_bus);
            end
            if (out_valid && out_ready) begin
                // Words of one packet must not be split by another port
                if (in_pkt) begin
                    check("out_bus.port", out_bus.port, pkt_port);
                end
                mon_idx = -1;
                for (int k = 0; k < exp_q.size(); k++) begin
                    if (mon_idx < 0 && exp_q[k].port == out_bus.port) begin
                        mon_idx = k;
                    end
                end
                if (mon_idx < 0) begin
                    $display("An output word from port %0d was not expected", out_bus.port);
                    report_failure();
                end
                check("out_bus.word", out_bus.word, exp_q[mon_idx].word);
                exp_q.delete(mon_idx);
                in_pkt   = !out_bus.word.last;
                pkt_port = out_bus.port;
            end
            stalled  = out_valid && !out_ready;
            held_bus = out_bus;
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int i;
        int j;
        reset         = 1'b1;
        beats8[0]     = '0;
        beats8[1]     = '0;
        beats8_valid  = '0;
        beat16        = '0;
        beat16_valid  = 1'b0;
        port_enable   = '1;
        cnt_clear     = '0;
        ovf_clear     = '0;
        out_ready     = 1'b0;
        out_cnt_clear = 1'b0;
        active        = '0;
        lcg_state     = 32'd68444;
        rdy_mode      = RDY_ALWAYS;
        grp_id        = 0;
        out_exp       = 0;
        ovf_exp       = '0;
        for (int p = 0; p < NP; p++) begin
            cnt_exp[p] = 0;
        end

        // Lengths 1 to 9 on every port, one packet at a time
        for (int p = 0; p < NP; p++) begin
            for (int len = 1; len <= 9; len++) begin
                add_row(p, len, 8'(48 * p + 5 * len), 1, RDY_ALWAYS, 0, 0);
            end
        end
        // port len start en ready ovf join
        add_row(0, 7,  8'h40, 1, RDY_ALWAYS, 0, 0);
        add_row(1, 5,  8'h60, 1, RDY_ALWAYS, 0, 1);
        add_row(2, 11, 8'h80, 1, RDY_ALWAYS, 0, 1);
        add_row(0, 13, 8'ha0, 1, RDY_RANDOM, 0, 0);
        add_row(1, 3,  8'hb0, 1, RDY_RANDOM, 0, 1);
        add_row(2, 9,  8'hc0, 1, RDY_RANDOM, 0, 1);
        add_row(0, 22, 8'h05, 1, RDY_RANDOM, 0, 0);
        add_row(1, 17, 8'h25, 1, RDY_RANDOM, 0, 1);
        add_row(2, 30, 8'h45, 1, RDY_RANDOM, 0, 1);
        // Disabled ports, alone and beside an enabled port
        add_row(1, 6,  8'hd0, 0, RDY_ALWAYS, 0, 0);
        add_row(0, 5,  8'he0, 0, RDY_ALWAYS, 0, 0);
        add_row(2, 8,  8'hf0, 1, RDY_ALWAYS, 0, 1);
        // Packets longer than the buffer with the sink stalled
        add_row(2, 80, 8'h20, 1, RDY_LOW,    1, 0);
        add_row(2, 6,  8'h33, 1, RDY_ALWAYS, 0, 0);
        add_row(0, 70, 8'h70, 1, RDY_LOW,    1, 0);
        add_row(0, 3,  8'h99, 1, RDY_RANDOM, 0, 0);

        for (int c = 0; c < 8; c++) begin
            tick();
        end
        reset = 1'b0;
        tick();
        check("out_valid", out_valid, 1'b0);
        check_counters();

        i = 0;
        while (i < rows.size()) begin
            j        = i;
            rdy_mode = rows[i].rmode;
            while (j < rows.size() && rows[j].grp == rows[i].grp) begin
                start_packet(rows[j]);
                j++;
            end
            drive_packets();
            wait_delivery();
            check_counters();
            i = j;
        end

        // All clears together return every counter and flag to zero
        cnt_clear     = '1;
        ovf_clear     = '1;
        out_cnt_clear = 1'b1;
        tick();
        cnt_clear     = '0;
        ovf_clear     = '0;
        out_cnt_clear = 1'b0;
        tick();
        for (int p = 0; p < NP; p++) begin
            cnt_exp[p] = 0;
        end
        ovf_exp = '0;
        out_exp = 0;
        check_counters();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
